/* Bender.yml */
package:
  name: mipsCore

sources:
  - include_dirs:
      - hw
    files:
      - hw/mipsPkg.sv
      - hw/controlDecoder.sv
      - hw/registerFile.sv
      - hw/alu.sv
      - hw/fetchUnit.sv
      - hw/mipsCore.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/mipsCoreChecker.sv
      - tb/mipsCoreTb.sv

/* hw/alu.sv */
`timescale 1ns/1ns

`include "mipsSettings.svh"

module alu (
	input mipsPkg::aluOpT aluOp,
	input logic [`DATA_WIDTH-1:0] a,
	input logic [`DATA_WIDTH-1:0] b,
	output logic [`DATA_WIDTH-1:0] result,
	output logic zero
);
	import mipsPkg::*;

	localparam int HALF = `DATA_WIDTH / 2;

	logic lessThan;

	assign lessThan = ($signed(a) < $signed(b)); // Signed compare for SLT

	always_comb begin
		case (aluOp)
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluAdd: result = a + b;
			aluNor: result = ~(a | b);
			aluXor: result = a ^ b;
			aluSub: result = a - b;
			aluSlt: result = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
			aluLui: result = {b[HALF-1:0], {HALF{1'b0}}}; // Immediate to upper half
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* hw/controlDecoder.sv */
`timescale 1ns/1ns

module controlDecoder (
	input mipsPkg::instrT instr,
	output mipsPkg::ctrlT ctrl
);
	import mipsPkg::*;

	always_comb begin
		ctrl = '0; // Inactive word, also the no-op
		case (instr.rType.opcode)
			opSpecial: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				case (instr.rType.funct)
					fnAdd, fnAddu: ctrl.aluOp = aluAdd;
					fnSubu: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr: ctrl.aluOp = aluOr;
					fnXor: ctrl.aluOp = aluXor;
					fnNor: ctrl.aluOp = aluNor;
					fnSlt: ctrl.aluOp = aluSlt;
					default: ctrl = '0; // Covers the all-zero word
				endcase
			end
			opAddi, opAddiu, opSlti: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.extendSign = 1'b1;
				ctrl.aluOp = (instr.iType.opcode == opSlti) ? aluSlt : aluAdd;
			end
			opAndi, opOri, opXori: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1; // Zero extended
				case (instr.iType.opcode)
					opAndi: ctrl.aluOp = aluAnd;
					opOri: ctrl.aluOp = aluOr;
					default: ctrl.aluOp = aluXor;
				endcase
			end
			opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluLui;
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.extendSign = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.extendSign = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			opBeq, opBne: begin
				ctrl.branchEq = (instr.iType.opcode == opBeq);
				ctrl.branchNe = (instr.iType.opcode == opBne);
				ctrl.extendSign = 1'b1; // Offset is signed
				ctrl.aluOp = aluSub;
			end
			opJ: begin
				ctrl.jump = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

/* hw/fetchUnit.sv */
`timescale 1ns/1ns

`include "mipsSettings.svh"

module fetchUnit (
	input logic Clk,
	input logic rstN,
	input logic branchTaken,
	input logic [`DATA_WIDTH-1:0] branchOffset,
	input logic jump,
	input logic [`TARGET_WIDTH-1:0] jumpTarget,
	output logic [`DATA_WIDTH-1:0] pc
);

	logic [`DATA_WIDTH-1:0] pcPlus4;
	logic [`DATA_WIDTH-1:0] branchAddr;
	logic [`DATA_WIDTH-1:0] jumpAddr;
	logic [`DATA_WIDTH-1:0] nextPc;

	assign pcPlus4 = pc + `DATA_WIDTH'd4;
	assign branchAddr = pcPlus4 + {branchOffset[`DATA_WIDTH-3:0], 2'b00}; // Word offset
	// Region bits come from the incremented PC
	assign jumpAddr = {pcPlus4[`DATA_WIDTH-1:`TARGET_WIDTH+2], jumpTarget, 2'b00};

	always_comb begin
		if (jump)
			nextPc = jumpAddr; // Jump wins over branch
		else if (branchTaken)
			nextPc = branchAddr;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

/* hw/mipsCore.sv */
`timescale 1ns/1ns

`include "mipsSettings.svh"

module mipsCore (
	input logic Clk,
	input logic rstN,
	output logic [`DATA_WIDTH-1:0] instrAddr,
	input logic [`DATA_WIDTH-1:0] instr,
	output logic [`DATA_WIDTH-1:0] dataAddr,
	output logic [`DATA_WIDTH-1:0] writeData,
	input logic [`DATA_WIDTH-1:0] readData,
	output logic memWrite,
	output logic memRead
);
	import mipsPkg::*;

	instrT instrWord;
	ctrlT ctrl;
	logic [`DATA_WIDTH-1:0] readData1;
	logic [`DATA_WIDTH-1:0] readData2;
	logic [`DATA_WIDTH-1:0] immExt;
	logic [`DATA_WIDTH-1:0] aluB;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic [`DATA_WIDTH-1:0] regWriteData;
	logic [`REG_ADDR_WIDTH-1:0] writeReg;
	logic zero;
	logic branchTaken;
	logic regWriteEn;

	assign instrWord = instrT'(instr);

	controlDecoder controlDecoder_i (
		.instr(instrWord),
		.ctrl(ctrl)
	);

	// Sign or zero extension of imm16
	assign immExt = ctrl.extendSign ?
		{{(`DATA_WIDTH-`IMM_WIDTH){instrWord.iType.imm16[`IMM_WIDTH-1]}}, instrWord.iType.imm16} :
		{{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, instrWord.iType.imm16};

	assign writeReg = ctrl.regDstRd ? instrWord.rType.rd : instrWord.rType.rt;
	assign aluB = ctrl.aluSrcImm ? immExt : readData2;
	assign regWriteData = ctrl.memToReg ? readData : aluResult; // Write-back select
	assign regWriteEn = ctrl.regWrite & rstN;

	registerFile registerFile_i (
		.Clk(Clk),
		.readAddr1(instrWord.rType.rs),
		.readAddr2(instrWord.rType.rt),
		.writeAddr(writeReg),
		.writeData(regWriteData),
		.writeEn(regWriteEn),
		.readData1(readData1),
		.readData2(readData2)
	);

	alu alu_i (
		.aluOp(ctrl.aluOp),
		.a(readData1),
		.b(aluB),
		.result(aluResult),
		.zero(zero)
	);

	assign branchTaken = (ctrl.branchEq & zero) | (ctrl.branchNe & ~zero);

	fetchUnit fetchUnit_i (
		.Clk(Clk),
		.rstN(rstN),
		.branchTaken(branchTaken),
		.branchOffset(immExt),
		.jump(ctrl.jump),
		.jumpTarget(instrWord.jType.target26),
		.pc(instrAddr)
	);

	assign dataAddr = aluResult;
	assign writeData = readData2; // Store data is rt
	assign memWrite = ctrl.memWrite & rstN;
	assign memRead = ctrl.memRead & rstN;

endmodule

/* hw/mipsPkg.sv */
`include "mipsSettings.svh"

package mipsPkg;

	typedef enum logic [`OPCODE_WIDTH-1:0] {
		opSpecial = 6'd0, // R-type group, decoded on funct
		opJ = 6'd2,
		opBeq = 6'd4,
		opBne = 6'd5,
		opAddi = 6'd8, // No overflow trap, same as ADDIU
		opAddiu = 6'd9,
		opSlti = 6'd10,
		opAndi = 6'd12,
		opOri = 6'd13,
		opXori = 6'd14,
		opLui = 6'd15,
		opLw = 6'd35,
		opSw = 6'd43
	} opcodeT;

	typedef enum logic [5:0] {
		fnAdd = 6'd32, // Same as ADDU
		fnAddu = 6'd33,
		fnSubu = 6'd35,
		fnAnd = 6'd36,
		fnOr = 6'd37,
		fnXor = 6'd38,
		fnNor = 6'd39,
		fnSlt = 6'd42
	} functT;

	typedef enum logic [3:0] {
		aluAnd = 4'd0,
		aluOr = 4'd1,
		aluAdd = 4'd2,
		aluNor = 4'd3,
		aluXor = 4'd4,
		aluSub = 4'd6,
		aluSlt = 4'd7,
		aluLui = 4'd10
	} aluOpT;

	// One instruction word seen through each of the three formats
	typedef union packed {
		struct packed {
			opcodeT opcode;
			logic [`REG_ADDR_WIDTH-1:0] rs;
			logic [`REG_ADDR_WIDTH-1:0] rt;
			logic [`REG_ADDR_WIDTH-1:0] rd;
			logic [4:0] shamt;
			functT funct;
		} rType;
		struct packed {
			opcodeT opcode;
			logic [`REG_ADDR_WIDTH-1:0] rs;
			logic [`REG_ADDR_WIDTH-1:0] rt;
			logic [`IMM_WIDTH-1:0] imm16;
		} iType;
		struct packed {
			opcodeT opcode;
			logic [`TARGET_WIDTH-1:0] target26;
		} jType;
	} instrT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic regDstRd; // Destination is rd, not rt
		logic aluSrcImm; // ALU B takes the immediate
		logic extendSign;
		logic branchEq;
		logic branchNe;
		logic jump;
		aluOpT aluOp;
	} ctrlT;

endpackage

/* hw/mipsSettings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Machine word, also the width of every address
`define DATA_WIDTH 32

// Register index and register count
`define REG_ADDR_WIDTH 5
`define NUM_REGS 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Instruction field widths
`define OPCODE_WIDTH 6
`define IMM_WIDTH 16
`define TARGET_WIDTH 26

`endif

/* hw/registerFile.sv */
`timescale 1ns/1ns

`include "mipsSettings.svh"

module registerFile (
	input logic Clk,
	input logic [`REG_ADDR_WIDTH-1:0] readAddr1,
	input logic [`REG_ADDR_WIDTH-1:0] readAddr2,
	input logic [`REG_ADDR_WIDTH-1:0] writeAddr,
	input logic [`DATA_WIDTH-1:0] writeData,
	input logic writeEn,
	output logic [`DATA_WIDTH-1:0] readData1,
	output logic [`DATA_WIDTH-1:0] readData2
);

	logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

	always_ff @(posedge Clk) begin
		if (writeEn && (writeAddr != '0)) begin // Register 0 is never written
			regs[writeAddr] <= writeData;
		end
	end

	always_comb begin
		readData1 = regs[readAddr1];
		readData2 = regs[readAddr2];
		if (readAddr1 == '0)
			readData1 = '0;
		if (readAddr2 == '0)
			readData2 = '0;
	end

endmodule

/* mipsCore.f */
+incdir+hw
hw/mipsPkg.sv
hw/controlDecoder.sv
hw/registerFile.sv
hw/alu.sv
hw/fetchUnit.sv
hw/mipsCore.sv
tb/mipsCoreChecker.sv
tb/mipsCoreTb.sv

/* tb/mipsCoreChecker.sv */
`timescale 1ns/1ns

`include "mipsSettings.svh"

module mipsCoreChecker (
	input logic Clk,
	input logic rstN,
	input logic [`DATA_WIDTH-1:0] instrAddr,
	input logic memWrite,
	input logic memRead
);

	int failures = 0;

	strobesExclusive: assert property (
		@(posedge Clk) disable iff (!rstN) !(memWrite && memRead)
	) else begin
		$error("memWrite and memRead are high in the same cycle");
		failures++;
	end

	fetchAligned: assert property (
		@(posedge Clk) disable iff (!rstN) instrAddr[1:0] == 2'b00
	) else begin
		$error("instrAddr 0x%h is not word aligned", instrAddr);
		failures++;
	end

	// PC restarts and no store leaves the core after a reset edge
	resetState: assert property (
		@(posedge Clk) !rstN |=> (instrAddr == `RESET_PC) && !memWrite
	) else begin
		$error("instrAddr or memWrite wrong in the cycle after a reset edge");
		failures++;
	end

endmodule

/* tb/mipsCoreTb.sv */
`timescale 1ns/1ns

`include "mipsSettings.svh"

module mipsCoreTb;
	import mipsPkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int RUN_CYCLES = 200;
	localparam int NUM_TESTS = 7;
	localparam int TIMEOUT_NS = (NUM_TESTS * (RUN_CYCLES + RESET_CYCLES + 2) + 20) * CLK_PERIOD;
	localparam int MEM_WORDS = 64;

	logic Clk;
	logic rstN;
	logic [`DATA_WIDTH-1:0] instrAddr;
	logic [`DATA_WIDTH-1:0] instr;
	logic [`DATA_WIDTH-1:0] dataAddr;
	logic [`DATA_WIDTH-1:0] writeData;
	logic [`DATA_WIDTH-1:0] readData;
	logic memWrite;
	logic memRead;

	logic [`DATA_WIDTH-1:0] imem [MEM_WORDS];
	logic [`DATA_WIDTH-1:0] dmem [MEM_WORDS];
	logic [`DATA_WIDTH-1:0] modelMem [MEM_WORDS];
	logic [`DATA_WIDTH-1:0] modelRegs [`NUM_REGS];
	logic [`DATA_WIDTH-1:0] modelPc;
	logic [31:0] rngState;
	int checkCount;
	int errorCount;
	int passCount;
	int failCount;
	functT rFuncts [8] = '{fnAdd, fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt};
	opcodeT iOps [7] = '{opAddi, opAddiu, opSlti, opAndi, opOri, opXori, opLui};

	mipsCore mipsCore_i (.*);

	bind mipsCore mipsCoreChecker mipsCoreChecker_i (.*);

	assign instr = imem[instrAddr[7:2]]; // Program memory, combinational read
	assign readData = dmem[dataAddr[7:2]];

	always @(posedge Clk) begin
		if (memWrite)
			dmem[dataAddr[7:2]] <= writeData;
	end

	initial begin
		Clk = 1'b0;
		forever #(CLK_PERIOD / 2) Clk = ~Clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function automatic int randBelow(int n);
		logic [31:0] r;
		r = nextRand();
		return int'(r[31:16]) % n; // Upper bits have the longer period
	endfunction

	function automatic logic [31:0] fillWord(int idx);
		logic [31:0] addr;
		addr = idx * 4;
		return (addr * 32'h9E37_79B1) ^ 32'h1357_9BDF;
	endfunction

	function automatic logic [31:0] iWord(opcodeT op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] rWord(functT fn, int rs, int rt, int rd);
		return {opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic int flowTarget(int idx);
		int t;
		t = idx + 1 + randBelow(6);
		if (t > MEM_WORDS - 2)
			t = 8 + randBelow(8); // Back to the start of the body
		return t;
	endfunction

	// r7 holds the data base and is never a destination
	function automatic logic [31:0] randomInstr(int focus, int idx);
		int cls;
		int pick;
		int t;
		logic [31:0] w;
		pick = randBelow(10);
		if (focus < 5 && randBelow(2) == 0)
			cls = focus;
		else
			cls = (pick < 3) ? 0 : (pick < 5) ? 1 : (pick < 7) ? 2 : (pick < 9) ? 3 : 4;
		case (cls)
			0: w = rWord(rFuncts[randBelow(8)], randBelow(8), randBelow(8), randBelow(7));
			1: w = iWord(iOps[randBelow(7)], randBelow(8), randBelow(7), 16'(nextRand() >> 16));
			2: begin
				if (randBelow(2) == 0)
					w = iWord(opLw, 7, randBelow(7), 16'(randBelow(MEM_WORDS) * 4));
				else
					w = iWord(opSw, 7, randBelow(8), 16'(randBelow(MEM_WORDS) * 4));
			end
			3: begin
				t = flowTarget(idx);
				pick = randBelow(3);
				if (pick == 0)
					w = iWord(opBeq, randBelow(8), randBelow(8), 16'(t - idx - 1));
				else if (pick == 1)
					w = iWord(opBne, randBelow(8), randBelow(8), 16'(t - idx - 1));
				else
					w = {opJ, 26'(t)};
			end
			default: w = (randBelow(2) == 0) ? '0 : {6'(16 + randBelow(16)), 26'(nextRand())};
		endcase
		return w;
	endfunction

	task automatic loadProgram(int focus);
		int i;
		imem[0] = iWord(opLui, 0, 7, 16'(nextRand() >> 16));
		imem[1] = iWord(opOri, 7, 7, 16'(nextRand() >> 16) & 16'hFF00); // 256-byte aligned base
		for (i = 2; i < 8; i++)
			imem[i] = iWord(opAddiu, 0, i - 1, 16'(nextRand() >> 16));
		for (i = 8; i < MEM_WORDS - 1; i++)
			imem[i] = randomInstr(focus, i);
		imem[MEM_WORDS - 1] = {opJ, 26'd8};
	endtask

	task automatic checkWord(string name, logic [31:0] got, logic [31:0] exp);
		checkCount++;
		assert (got === exp)
		else begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
			errorCount++;
		end
	endtask

	// One instruction of the reference model, checked against the DUT's bus
	task automatic checkAndStep();
		instrT iw;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immS;
		logic [31:0] immZ;
		logic [31:0] addr;
		logic [31:0] wval;
		logic [31:0] nextPc;
		logic [4:0] dest;
		logic wr;
		logic memRd;
		logic memWr;
		iw = instrT'(imem[modelPc[7:2]]);
		a = modelRegs[iw.iType.rs];
		b = modelRegs[iw.iType.rt];
		immS = {{16{iw.iType.imm16[15]}}, iw.iType.imm16};
		immZ = {16'd0, iw.iType.imm16};
		addr = a + immS;
		dest = iw.iType.rt;
		wval = '0;
		wr = 1'b1;
		nextPc = modelPc + 32'd4;
		case (iw.iType.opcode)
			opSpecial: begin
				dest = iw.rType.rd;
				case (iw.rType.funct)
					fnAdd, fnAddu: wval = a + b;
					fnSubu: wval = a - b;
					fnAnd: wval = a & b;
					fnOr: wval = a | b;
					fnXor: wval = a ^ b;
					fnNor: wval = ~(a | b);
					fnSlt: wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			opAddi, opAddiu: wval = addr;
			opSlti: wval = ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0;
			opAndi: wval = a & immZ;
			opOri: wval = a | immZ;
			opXori: wval = a ^ immZ;
			opLui: wval = {iw.iType.imm16, 16'd0};
			opLw: wval = modelMem[addr[7:2]];
			default: wr = 1'b0;
		endcase
		memRd = (iw.iType.opcode == opLw);
		memWr = (iw.iType.opcode == opSw);
		if ((iw.iType.opcode == opBeq && a == b) || (iw.iType.opcode == opBne && a != b))
			nextPc = modelPc + 32'd4 + (immS << 2);
		if (iw.iType.opcode == opJ)
			nextPc = {nextPc[31:28], iw.jType.target26, 2'b00};
		checkWord("instrAddr", instrAddr, modelPc);
		checkWord("memWrite", 32'(memWrite), 32'(memWr));
		checkWord("memRead", 32'(memRead), 32'(memRd));
		if (memWr || memRd)
			checkWord("dataAddr", dataAddr, addr);
		if (memWr)
			checkWord("writeData", writeData, b);
		if (memWr)
			modelMem[addr[7:2]] = b;
		if (wr && dest != '0)
			modelRegs[dest] = wval;
		modelPc = nextPc;
	endtask

	task automatic runTest(string name, int focus, int cycles);
		int i;
		logic [31:0] firstWord;
		checkCount = 0;
		errorCount = 0;
		@(posedge Clk);
		#5;
		rstN = 1'b0;
		loadProgram(focus);
		firstWord = imem[0];
		imem[0] = iWord(opSw, 7, 1, 16'd0); // Store and load at the reset PC, strobes must stay off
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(negedge Clk);
			checkWord("memWrite", 32'(memWrite), 32'd0);
			checkWord("memRead", 32'(memRead), 32'd0);
			if (i > 0)
				checkWord("instrAddr", instrAddr, `RESET_PC);
			imem[0] = (i % 2 == 0) ? iWord(opLw, 7, 1, 16'd0) : iWord(opSw, 7, 1, 16'd0);
			@(posedge Clk);
		end
		#5;
		imem[0] = firstWord;
		rstN = 1'b1;
		modelPc = `RESET_PC;
		for (i = 0; i < cycles; i++) begin
			@(negedge Clk); // Bus outputs settled mid-cycle
			checkAndStep();
		end
		if (errorCount == 0) begin
			passCount++;
			$display("Test %s passed, %0d checks", name, checkCount);
		end else begin
			failCount++;
			$display("Test %s failed, %0d of %0d checks wrong", name, errorCount, checkCount);
		end
	endtask

	initial begin
		int i;
		rngState = 32'd24;
		rstN = 1'b0;
		passCount = 0;
		failCount = 0;
		for (i = 0; i < MEM_WORDS; i++) begin
			imem[i] = '0;
			dmem[i] = fillWord(i);
			modelMem[i] = fillWord(i);
		end
		for (i = 0; i < `NUM_REGS; i++)
			modelRegs[i] = '0;
		runTest("reset", 5, 0);
		runTest("registerAlu", 0, RUN_CYCLES);
		runTest("immediate", 1, RUN_CYCLES);
		runTest("loadStore", 2, RUN_CYCLES);
		runTest("branchJump", 3, RUN_CYCLES);
		runTest("noop", 4, RUN_CYCLES);
		runTest("mixed", 5, RUN_CYCLES);
		$display("Tests passed: %0d, failed: %0d, bus assertion failures: %0d",
			passCount, failCount, mipsCore_i.mipsCoreChecker_i.failures);
		if (failCount == 0 && mipsCore_i.mipsCoreChecker_i.failures == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
